/* filelist.f */
source/bp_pkg.sv
source/btb_4way.sv
source/local_branch_predictor_no_bht.sv
source/branch_predictor.sv
sim/branch_predictor_checker.sv
sim/branch_predictor_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the branch predictor testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module branch_predictor_tb \
    -f filelist.f \
    --Mdir obj_dir -o branch_predictor_sim

# keep running after an assertion so the testbench can print its summary
./obj_dir/branch_predictor_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* sim/branch_predictor_checker.sv */
`timescale 1ns/1ps

module branch_predictor_checker
    import bp_pkg::*;
(
    input logic            clk,
    input logic            rst_n,
    input logic [PC_W-1:0] predict_pc,
    input logic [PC_W-1:0] predicted_pc,
    input logic [PC_W-1:0] predicted_target_pc,    // BTB target output
    input logic            target_valid,           // BTB hit
    input logic            prediction              // counter msb
);

    int unsigned     fail_count = 0;               // failed assertions so far
    logic [PC_W-1:0] seq_pc;

    assign seq_pc = predict_pc + PC_W'(INSTR_BYTES);

    // first cycle out of reset has empty tables
    reset_fall_through: assert property (@(posedge clk) $rose(rst_n) |-> predicted_pc == seq_pc)
        else begin
            fail_count++;
            $error("predicted_pc is not pc+4 in the first cycle after reset");
        end

    // only two legal sources for the next fetch address
    legal_source: assert property (@(posedge clk) disable iff (!rst_n)
        predicted_pc == seq_pc || predicted_pc == predicted_target_pc)
        else begin
            fail_count++;
            $error("predicted_pc is neither pc+4 nor the BTB target");
        end

    redirect_needs_hit_and_taken: assert property (@(posedge clk) disable iff (!rst_n)
        predicted_pc != seq_pc |-> target_valid && prediction)
        else begin
            fail_count++;
            $error("redirect without a BTB hit and a taken counter");
        end

    outputs_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({predicted_pc, target_valid, prediction}))
        else begin
            fail_count++;
            $error("unknown value on a predictor output");
        end

endmodule

bind branch_predictor branch_predictor_checker checker_inst (
    .clk                 (clk),
    .rst_n               (rst_n),
    .predict_pc          (predict_pc),
    .predicted_pc        (predicted_pc),
    .predicted_target_pc (predicted_target_pc),
    .target_valid        (target_valid),
    .prediction          (prediction)
);

/* sim/branch_predictor_tb.sv */
`timescale 1ns/1ps

module branch_predictor_tb
    import bp_pkg::*;
();

    localparam int CLK_PERIOD        = 20;          // ns
    localparam int DRIVE_DELAY       = 2;           // inputs change this long after the edge
    localparam int SAMPLE_LEAD       = 2;           // outputs read this long before the edge
    localparam int RAND_SEED         = 87203;
    localparam int RANDOM_CYCLES     = 300;
    localparam int RESET_WAIT_CYCLES = 10;          // cycles allowed for the fall through after reset
    localparam int SIM_LIMIT_NS      = 100000;      // whole run watchdog

    logic            clk;
    logic            rst_n;
    logic [PC_W-1:0] predict_pc;
    logic [PC_W-1:0] update_pc;
    logic            valid;
    logic            branch_taken;
    logic [PC_W-1:0] target_pc;
    logic [PC_W-1:0] predicted_pc;

    // behavioral copy of both tables
    logic [BTB_WAYS-1:0]  m_valid  [BTB_SETS];
    logic [BTB_TAG_W-1:0] m_tag    [BTB_SETS][BTB_WAYS];
    logic [PC_W-1:0]      m_target [BTB_SETS][BTB_WAYS];
    logic [PLRU_W-1:0]    m_plru   [BTB_SETS];     // bit 0 root, bit 1 ways 0/1, bit 2 ways 2/3
    logic [CTR_W-1:0]     m_ctr    [PHT_ENTRIES];

    int              errors;
    int              checks;
    int              test_errors_start;
    int              test_checks_start;
    logic [PC_W-1:0] last_out;                      // predicted_pc seen by the latest cycle
    logic [PC_W-1:0] pool [8];                      // pcs for the random mix

    branch_predictor branch_predictor_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .predict_pc   (predict_pc),
        .update_pc    (update_pc),
        .valid        (valid),
        .branch_taken (branch_taken),
        .target_pc    (target_pc),
        .predicted_pc (predicted_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // hard stop in case a loop never exits
    initial begin
        #(SIM_LIMIT_NS);
        $display("Watchdog: simulation ran past %0d ns without completing the tests", SIM_LIMIT_NS);
        $display("Finished with errors");
        $finish;
    end

    task automatic model_reset();
        for (int s = 0; s < BTB_SETS; s++) begin
            m_valid[s] = '0;                        // every way empty
            m_plru[s]  = '0;
        end
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            m_ctr[i] = CTR_RESET;                   // weakly not taken
        end
    endtask

    // next fetch address from the model state
    function automatic logic [PC_W-1:0] model_predict(input logic [PC_W-1:0] pc);
        logic [BTB_IDX_W-1:0] idx;
        logic [BTB_TAG_W-1:0] tag;
        logic                 hit;
        logic [PC_W-1:0]      tgt;
        logic                 taken;
        idx   = pc[BTB_IDX_LSB +: BTB_IDX_W];       // pc bits 5 to 2
        tag   = pc[BTB_TAG_LSB +: BTB_TAG_W];       // pc bits 31 to 6
        hit   = 1'b0;
        tgt   = '0;
        for (int w = 0; w < BTB_WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                hit = 1'b1;
                tgt = m_target[idx][w];
            end
        end
        taken = m_ctr[pc[PHT_IDX_LSB +: PHT_IDX_W]][CTR_W-1];  // counter msb
        return (hit && taken) ? tgt : pc + PC_W'(INSTR_BYTES);
    endfunction

    // one resolved instruction applied to the model
    task automatic model_update(input logic [PC_W-1:0] pc, input logic taken,
                                input logic [PC_W-1:0] tgt);
        logic [BTB_IDX_W-1:0] idx;
        logic [BTB_TAG_W-1:0] tag;
        logic [PHT_IDX_W-1:0] pidx;
        logic [BTB_WAY_W-1:0] way;
        logic                 found;
        logic [PLRU_W-1:0]    p;
        logic [CTR_W-1:0]     c;
        idx   = pc[BTB_IDX_LSB +: BTB_IDX_W];
        tag   = pc[BTB_TAG_LSB +: BTB_TAG_W];
        pidx  = pc[PHT_IDX_LSB +: PHT_IDX_W];
        way   = '0;
        found = 1'b0;
        for (int w = 0; w < BTB_WAYS; w++) begin
            if (!found && m_valid[idx][w] && m_tag[idx][w] == tag) begin
                way   = BTB_WAY_W'(w);              // hit way keeps its slot
                found = 1'b1;
            end
        end
        for (int w = 0; w < BTB_WAYS; w++) begin
            if (!found && !m_valid[idx][w]) begin
                way   = BTB_WAY_W'(w);              // lowest empty way
                found = 1'b1;
            end
        end
        if (!found) begin
            p = m_plru[idx];
            case (p[0])
                1'b0:    way = {1'b0, p[1]};        // left half
                default: way = {1'b1, p[2]};        // right half
            endcase
        end
        m_valid[idx][way]  = 1'b1;
        m_tag[idx][way]    = tag;
        m_target[idx][way] = tgt;                   // target kept even when not taken
        m_plru[idx][0]     = ~way[1];               // point away from the used half
        if (way[1]) begin
            m_plru[idx][2] = ~way[0];
        end else begin
            m_plru[idx][1] = ~way[0];
        end
        c = m_ctr[pidx];
        if (taken && c != CTR_MAX) begin
            c = c + 1'b1;
        end else if (!taken && c != CTR_MIN) begin
            c = c - 1'b1;
        end
        m_ctr[pidx] = c;                            // saturates at both ends
    endtask

    task automatic check_value(input string name, input logic [PC_W-1:0] want,
                               input logic [PC_W-1:0] got);
        checks++;
        assert (got === want) else begin
            $display("Error at %0d ns: %s expected 0x%08h got 0x%08h", $time, name, want, got);
            errors++;
        end
    endtask

    // drive one cycle, compare just before the edge, then advance the model
    task automatic run_cycle(input logic [PC_W-1:0] pc, input logic v,
                             input logic [PC_W-1:0] upc, input logic tk,
                             input logic [PC_W-1:0] tgt);
        predict_pc   = pc;
        valid        = v;
        update_pc    = upc;
        branch_taken = tk;
        target_pc    = tgt;
        #(CLK_PERIOD - DRIVE_DELAY - SAMPLE_LEAD);
        last_out = predicted_pc;
        check_value("predicted_pc", model_predict(pc), last_out);  // lookup sees old state
        @(posedge clk);
        if (v) begin
            model_update(upc, tk, tgt);
        end
        #(DRIVE_DELAY);
    endtask

    task automatic predict_only(input logic [PC_W-1:0] pc);
        run_cycle(pc, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic update_only(input logic [PC_W-1:0] pc, input logic tk,
                               input logic [PC_W-1:0] tgt);
        run_cycle(pc, 1'b1, pc, tk, tgt);           // fetch the same pc during the update
    endtask

    // compare the latest sample with a value worked out by hand
    task automatic expect_out(input logic [PC_W-1:0] want);
        check_value("predicted_pc", want, last_out);
    endtask

    task automatic apply_reset();
        int cycles;
        rst_n        = 1'b0;
        valid        = 1'b0;
        branch_taken = 1'b0;
        predict_pc   = '0;
        update_pc    = '0;
        target_pc    = '0;
        repeat (2) @(posedge clk);
        model_reset();
        #(DRIVE_DELAY);
        rst_n  = 1'b1;
        cycles = 0;
        while (predicted_pc !== predict_pc + PC_W'(INSTR_BYTES) && cycles < RESET_WAIT_CYCLES) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            cycles++;
        end
        if (predicted_pc !== predict_pc + PC_W'(INSTR_BYTES)) begin
            $display("Timeout: predicted_pc did not fall through to pc+4 within %0d cycles of reset",
                     RESET_WAIT_CYCLES);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_errors_start = errors;
        test_checks_start = checks;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s, %0d checks, %0d errors", name,
                 (errors == test_errors_start) ? "pass" : "fail",
                 checks - test_checks_start, errors - test_errors_start);
    endtask

    initial begin
        logic [PC_W-1:0] pc;
        logic [PC_W-1:0] upc;
        logic [PC_W-1:0] tgt;
        logic            v;
        logic            tk;
        int              checker_fails;
        clk      = 1'b0;
        errors   = 0;
        checks   = 0;
        void'($urandom(RAND_SEED));                 // the only seeding of the run
        apply_reset();

        begin_test();
        for (int i = 0; i < 64; i++) begin
            pc = 32'h0000_1000 + 32'(4 * i);        // walks every set and every counter
            predict_only(pc);
            expect_out(pc + 32'd4);
        end
        for (int i = 0; i < 16; i++) begin
            pc = $urandom() & 32'hFFFF_FFFC;
            predict_only(pc);
            expect_out(pc + 32'd4);
        end
        end_test("reset_fall_through");

        begin_test();
        update_only(32'h0000_2024, 1'b1, 32'h0000_3000);   // counter 01 to 10
        expect_out(32'h0000_2028);                         // same cycle sees the old state
        predict_only(32'h0000_2024);
        expect_out(32'h0000_3000);
        update_only(32'h0000_2024, 1'b1, 32'h0000_3000);   // 11
        update_only(32'h0000_2024, 1'b1, 32'h0000_3000);   // stays at 11
        predict_only(32'h0000_2024);
        expect_out(32'h0000_3000);
        update_only(32'h0000_2024, 1'b0, 32'h0000_3000);   // 10
        predict_only(32'h0000_2024);
        expect_out(32'h0000_3000);
        update_only(32'h0000_2024, 1'b0, 32'h0000_3000);   // 01 with the BTB still hitting
        predict_only(32'h0000_2024);
        expect_out(32'h0000_2028);
        end_test("training_and_saturation");

        begin_test();
        update_only(32'h0000_2024, 1'b1, 32'h0000_3400);   // back to 10 with a new target
        predict_only(32'h0000_2024);
        expect_out(32'h0000_3400);
        end_test("target_replacement");

        begin_test();
        for (int i = 0; i < 5; i++) begin
            pc = 32'h0000_0100 + 32'(32'h40 * i);   // all in set 0
            update_only(pc, 1'b1, pc + 32'h1000);
            update_only(pc, 1'b1, pc + 32'h1000);
        end
        predict_only(32'h0000_0100);                // evicted from way 0
        expect_out(32'h0000_0104);
        for (int i = 1; i < 5; i++) begin
            pc = 32'h0000_0100 + 32'(32'h40 * i);
            predict_only(pc);
            expect_out(pc + 32'h1000);
        end
        end_test("set_conflict_plru");

        begin_test();
        pool[0] = 32'h0000_000C;                    // first five share set 3
        pool[1] = 32'h0000_004C;
        pool[2] = 32'h0000_008C;
        pool[3] = 32'h0000_00CC;
        pool[4] = 32'h0000_010C;
        pool[5] = 32'h0000_2024;                    // already trained
        pool[6] = 32'h0000_0030;
        pool[7] = 32'h0000_0070;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            pc  = pool[3'($urandom_range(0, 7))];
            upc = pool[3'($urandom_range(0, 7))];
            v   = ($urandom_range(0, 3) != 0);      // mostly busy update port
            tk  = ($urandom_range(0, 2) != 0);      // biased toward taken
            tgt = $urandom() & 32'hFFFF_FFFC;
            run_cycle(pc, v, upc, tk, tgt);
        end
        predict_only('0);                           // drops valid
        end_test("random_mix");

        checker_fails = int'(branch_predictor_inst.checker_inst.fail_count);
        $display("summary: %0d checks passed, %0d failed, %0d assertion failures",
                 checks - errors, errors, checker_fails);
        if (errors == 0 && checker_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* source/bp_pkg.sv */
package bp_pkg;

    // datapath widths
    localparam int unsigned PC_W        = 32;                   // rv32 pc width
    localparam int unsigned INSTR_BYTES = 4;                    // sequential fetch step

    // branch target buffer geometry
    localparam int unsigned BTB_WAYS    = 4;                    // ways per set
    localparam int unsigned BTB_SETS    = 16;                   // number of sets
    localparam int unsigned BTB_WAY_W   = $clog2(BTB_WAYS);     // way number width
    localparam int unsigned BTB_IDX_LSB = 2;                    // set index starts above byte offset
    localparam int unsigned BTB_IDX_W   = $clog2(BTB_SETS);     // pc bits 5 down to 2
    localparam int unsigned BTB_TAG_LSB = BTB_IDX_LSB + BTB_IDX_W; // tag starts at pc bit 6
    localparam int unsigned BTB_TAG_W   = PC_W - BTB_TAG_LSB;   // 26 tag bits

    // tree pseudo lru state per set
    // bit 0 is the root and picks a half
    // bit 1 picks inside ways 0 and 1
    // bit 2 picks inside ways 2 and 3
    localparam int unsigned PLRU_W      = BTB_WAYS - 1;         // 3 tree bits

    // pattern history table
    localparam int unsigned PHT_IDX_LSB = 2;                    // index starts above byte offset
    localparam int unsigned PHT_IDX_W   = 6;                    // pc bits 7 down to 2
    localparam int unsigned PHT_ENTRIES = 1 << PHT_IDX_W;       // 64 counters

    // 2-bit saturating counter encodings
    localparam int unsigned CTR_W = 2;                          // counter width
    localparam logic [CTR_W-1:0] CTR_MIN   = 2'b00;             // strongly not taken
    localparam logic [CTR_W-1:0] CTR_RESET = 2'b01;             // weakly not taken
    localparam logic [CTR_W-1:0] CTR_MAX   = 2'b11;             // strongly taken

endpackage

/* source/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor
    import bp_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic [PC_W-1:0] predict_pc,     // pc of IF
    input  logic [PC_W-1:0] update_pc,      // pc of the resolved instruction in EX
    input  logic            valid,          // branch jal or jalr resolved in EX
    input  logic            branch_taken,   // resolved direction
    input  logic [PC_W-1:0] target_pc,      // resolved target
    output logic [PC_W-1:0] predicted_pc    // next fetch address
);

    logic [PC_W-1:0] predicted_target_pc;   // stored target for predict_pc
    logic            target_valid;          // BTB hit
    logic            prediction;            // counter says taken
    logic [PC_W-1:0] seq_pc;                // fall through address

    btb_4way branch_target_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .predict_pc   (predict_pc),         // lookup with the fetch pc
        .update_pc    (update_pc),          // allocate or refresh this pc
        .valid        (valid),
        .target_pc    (target_pc),          // written even for not taken updates
        .predicted_pc (predicted_target_pc),
        .prediction   (target_valid)
    );

    local_branch_predictor_no_bht local_branch_predictor (
        .clk                 (clk),
        .rst_n               (rst_n),
        .update_branch_pc    (update_pc),   // counter to train
        .predict_branch_pc   (predict_pc),  // counter to read
        .valid               (valid),
        .actual_branch_taken (branch_taken),
        .prediction          (prediction)
    );

    assign seq_pc = predict_pc + PC_W'(INSTR_BYTES);

    // redirect only when the target is known and the direction is taken
    assign predicted_pc = (target_valid && prediction) ? predicted_target_pc : seq_pc;

endmodule

/* source/btb_4way.sv */
`timescale 1ns/1ps

module btb_4way
    import bp_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic [PC_W-1:0] predict_pc,     // fetch pc from IF
    input  logic [PC_W-1:0] update_pc,      // resolved pc from EX
    input  logic            valid,          // one resolved control transfer this cycle
    input  logic [PC_W-1:0] target_pc,      // resolved target from EX
    output logic [PC_W-1:0] predicted_pc,   // stored target of the hit way
    output logic            prediction      // lookup hit
);

    // per set state
    logic [BTB_WAYS-1:0]  valid_q  [BTB_SETS];              // way valid bits
    logic [BTB_TAG_W-1:0] tag_q    [BTB_SETS][BTB_WAYS];    // way tags
    logic [PC_W-1:0]      target_q [BTB_SETS][BTB_WAYS];    // way targets
    logic [PLRU_W-1:0]    plru_q   [BTB_SETS];              // tree bits

    // lookup side
    logic [BTB_IDX_W-1:0] pred_idx;
    logic [BTB_TAG_W-1:0] pred_tag;
    logic [BTB_WAYS-1:0]  pred_hit_vec;                     // one hot on a tag match

    // update side
    logic [BTB_IDX_W-1:0] upd_idx;
    logic [BTB_TAG_W-1:0] upd_tag;
    logic [BTB_WAYS-1:0]  upd_hit_vec;
    logic                 upd_hit;
    logic [BTB_WAY_W-1:0] upd_hit_way;
    logic                 free_found;                       // set has an empty way
    logic [BTB_WAY_W-1:0] free_way;                         // lowest empty way
    logic [PLRU_W-1:0]    upd_plru;                         // tree bits of the update set
    logic [BTB_WAY_W-1:0] victim_way;                       // tree choice when the set is full
    logic [BTB_WAY_W-1:0] alloc_way;                        // way written by this update
    logic [PLRU_W-1:0]    plru_next;                        // tree bits after touching alloc_way

    assign pred_idx = predict_pc[BTB_IDX_LSB +: BTB_IDX_W];
    assign pred_tag = predict_pc[BTB_TAG_LSB +: BTB_TAG_W];
    assign upd_idx  = update_pc[BTB_IDX_LSB +: BTB_IDX_W];
    assign upd_tag  = update_pc[BTB_TAG_LSB +: BTB_TAG_W];

    // lookup compares all four ways of the indexed set
    always_comb begin
        for (int w = 0; w < BTB_WAYS; w++) begin
            pred_hit_vec[w] = valid_q[pred_idx][w] && (tag_q[pred_idx][w] == pred_tag);
        end
    end

    // target mux of the hit way
    always_comb begin
        predicted_pc = '0;                                  // no hit gives zero
        for (int w = 0; w < BTB_WAYS; w++) begin
            if (pred_hit_vec[w]) begin
                predicted_pc = target_q[pred_idx][w];
            end
        end
    end

    assign prediction = |pred_hit_vec;

    // tag match for the update pc
    always_comb begin
        upd_hit_way = '0;
        for (int w = 0; w < BTB_WAYS; w++) begin
            upd_hit_vec[w] = valid_q[upd_idx][w] && (tag_q[upd_idx][w] == upd_tag);
            if (upd_hit_vec[w]) begin
                upd_hit_way = BTB_WAY_W'(w);
            end
        end
    end

    assign upd_hit = |upd_hit_vec;

    // scan downward so the lowest empty way is the last one kept
    always_comb begin
        free_found = 1'b0;
        free_way   = '0;
        for (int w = BTB_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[upd_idx][w]) begin
                free_found = 1'b1;
                free_way   = BTB_WAY_W'(w);
            end
        end
    end

    assign upd_plru = plru_q[upd_idx];

    // root selects the half and the half bit selects the way
    assign victim_way = upd_plru[0] ? {1'b1, upd_plru[2]}  // right half ways 2 and 3
                                    : {1'b0, upd_plru[1]}; // left half ways 0 and 1

    // hit way first then empty way then the tree victim
    always_comb begin
        if (upd_hit) begin
            alloc_way = upd_hit_way;
        end else if (free_found) begin
            alloc_way = free_way;
        end else begin
            alloc_way = victim_way;
        end
    end

    // touch points every bit on the path away from alloc_way
    always_comb begin
        plru_next    = upd_plru;
        plru_next[0] = ~alloc_way[1];                       // root to the other half
        if (alloc_way[1]) begin
            plru_next[2] = ~alloc_way[0];                   // right half to the sibling
        end else begin
            plru_next[1] = ~alloc_way[0];                   // left half to the sibling
        end
    end

    // control state with synchronous reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < BTB_SETS; s++) begin
                valid_q[s] <= '0;                           // all ways empty
                plru_q[s]  <= '0;
            end
        end else if (valid) begin
            valid_q[upd_idx][alloc_way] <= 1'b1;
            plru_q[upd_idx]             <= plru_next;       // only updates touch the tree
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        if (valid) begin
            tag_q[upd_idx][alloc_way]    <= upd_tag;        // same tag again on a hit
            target_q[upd_idx][alloc_way] <= target_pc;      // newest target wins
        end
    end

endmodule

/* source/local_branch_predictor_no_bht.sv */
`timescale 1ns/1ps

module local_branch_predictor_no_bht
    import bp_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic [PC_W-1:0] update_branch_pc,       // resolved pc from EX
    input  logic [PC_W-1:0] predict_branch_pc,      // fetch pc from IF
    input  logic            valid,                  // train strobe
    input  logic            actual_branch_taken,    // resolved direction
    output logic            prediction              // taken guess for the fetch pc
);

    // pattern table of 2-bit counters
    // indexed straight from pc so branches sharing bits 7 to 2 alias
    logic [CTR_W-1:0]     ctr_q [PHT_ENTRIES];

    logic [PHT_IDX_W-1:0] pred_idx;                 // counter read by the fetch pc
    logic [PHT_IDX_W-1:0] upd_idx;                  // counter trained by EX
    logic [CTR_W-1:0]     ctr_cur;                  // counter before training
    logic [CTR_W-1:0]     ctr_next;                 // counter after one step

    assign pred_idx = predict_branch_pc[PHT_IDX_LSB +: PHT_IDX_W];
    assign upd_idx  = update_branch_pc[PHT_IDX_LSB +: PHT_IDX_W];

    // msb set means 10 or 11
    assign prediction = ctr_q[pred_idx][CTR_W-1];

    assign ctr_cur = ctr_q[upd_idx];

    // one step with saturation at both ends
    always_comb begin
        ctr_next = ctr_cur;
        if (actual_branch_taken) begin
            if (ctr_cur != CTR_MAX) begin
                ctr_next = ctr_cur + 1'b1;          // step toward strongly taken
            end
        end else begin
            if (ctr_cur != CTR_MIN) begin
                ctr_next = ctr_cur - 1'b1;          // step toward strongly not taken
            end
        end
    end

    // counters hold the direction state so every entry resets
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                ctr_q[i] <= CTR_RESET;              // weakly not taken
            end
        end else if (valid) begin
            ctr_q[upd_idx] <= ctr_next;
        end
    end

endmodule
